// File: dram_ctrl_top.f
+incdir+include
logic/dram_pkg.sv
logic/dram_apb_regs.sv
logic/dram_refresh_timer.sv
logic/dram_addr_gen.sv
logic/dram_ctrl_fsm.sv
logic/dram_ctrl_top.sv
tests/dram_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the DRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f dram_ctrl_top.f \
    --top-module dram_ctrl_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vdram_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: tests/dram_ctrl_tb.sv
// random transfers from a fixed seed, assumes zero-wait APB and a bus monitor that sees every cycle
`timescale 1ns/1ps
`include "dram_defines.svh"

module dram_ctrl_tb import dram_pkg::*; ();

    localparam int NXFER = 10;   // 6 row walk, then column, refresh, completion, refresh off
    localparam int ADDR_SPACE = `DRAM_BANKS * `DRAM_ROWS;

    logic        clk;
    logic        rst_b;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    dram_bus_s   bus;

    string cur_test;
    int    errors;
    int    mon_errors;
    int    test_err_base;
    int    tests_run;
    int    tests_failed;
    int    budget;
    int    xfer_len [NXFER];

    // monitor state
    int    acts;
    int    ref_runs;
    int    ref_cycles;
    int    ref_len;
    int    next_col;
    int    exp_lin;
    int    act_lin;
    logic  row_open;

    // model inputs, set by the stimulus before each start
    int    exp_base;
    int    acts_base;

    int          i;
    int          bank;
    int          row;
    int          refi;
    int          runs_before;
    int          cycles_before;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] stat;

    dram_ctrl_top dut_i (
        .clk     (clk),
        .rst_b   (rst_b),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .bus     (bus)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH %s: %s expected %0h actual %0h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %s: %s", cur_test, msg);
        errors++;
    endtask

    task automatic open_test(input string name);
        cur_test = name;
        test_err_base = errors + mon_errors;
    endtask

    task automatic close_test();
        tests_run++;
        if (errors + mon_errors != test_err_base) begin
            tests_failed++;
            $display("test %s: FAIL", cur_test);
        end else begin
            $display("test %s: PASS", cur_test);
        end
    endtask

    // setup cycle, then one access cycle with no wait state
    task automatic bus_cycle(input logic write, input logic [7:0] addr,
                             input logic [31:0] data, output logic [31:0] rd);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        if (pready !== 1'b1) report_mismatch("pready", 32'h1, {31'h0, pready});
        rd      = prdata;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'h0, data);
    endtask

    task automatic run_transfer(input int b, input int r, input int len, input int ri);
        write_reg(`DRAM_REG_ADDR, (32'(b) << 8) | 32'(r));
        write_reg(`DRAM_REG_LEN, 32'(len));
        write_reg(`DRAM_REG_REFI, 32'(ri));
        exp_base  = b * `DRAM_ROWS + r;
        acts_base = acts;
        write_reg(`DRAM_REG_CTRL, 32'h1);
    endtask

    task automatic wait_done(output logic [31:0] st);
        st = '0;
        while (!st[1]) read_reg(`DRAM_REG_STAT, st);
    endtask

    // bus monitor and row/refresh model
    always @(posedge clk) begin
        if (!rst_b) begin
            if (bus.cmd != CMD_REF && ref_len != 0) begin
                if (ref_len != `DRAM_REF_CYCLES) begin
                    $display("MISMATCH %s: REF run length expected %0d actual %0d",
                             cur_test, `DRAM_REF_CYCLES, ref_len);
                    mon_errors++;
                end
                ref_runs++;
                ref_len = 0;
            end
            case (bus.cmd)
                CMD_ACT: begin
                    if (row_open) begin
                        $display("ERROR %s: ACT issued while a row is open", cur_test);
                        mon_errors++;
                    end
                    exp_lin = (exp_base + acts - acts_base) % ADDR_SPACE;   // row-to-bank carry
                    act_lin = int'(bus.bank) * `DRAM_ROWS + int'(bus.row);
                    if (act_lin != exp_lin) begin
                        $display("MISMATCH %s: ACT bank*rows+row expected %0d actual %0d",
                                 cur_test, exp_lin, act_lin);
                        mon_errors++;
                    end
                    acts++;
                    row_open = 1'b1;
                    next_col = 0;
                end
                CMD_RD: begin
                    if (!row_open) begin
                        $display("ERROR %s: RD issued with no open row", cur_test);
                        mon_errors++;
                    end else if (int'(bus.col) != next_col) begin
                        $display("MISMATCH %s: RD column expected %0d actual %0d",
                                 cur_test, next_col, bus.col);
                        mon_errors++;
                    end
                    next_col++;
                end
                CMD_PRE: begin
                    if (!row_open) begin
                        $display("ERROR %s: PRE issued with no open row", cur_test);
                        mon_errors++;
                    end else if (next_col != `DRAM_COLS) begin
                        $display("MISMATCH %s: RD count before PRE expected %0d actual %0d",
                                 cur_test, `DRAM_COLS, next_col);
                        mon_errors++;
                    end
                    row_open = 1'b0;
                end
                CMD_REF: begin
                    if (row_open) begin
                        $display("ERROR %s: REF issued while a row is open", cur_test);
                        mon_errors++;
                    end
                    ref_len++;
                    ref_cycles++;
                end
                default: begin
                    if (row_open) begin
                        $display("ERROR %s: idle cycle inside a row burst", cur_test);
                        mon_errors++;
                    end
                end
            endcase
        end
    end

    // watchdog, armed at reset release once the lengths are drawn
    initial begin
        @(negedge rst_b);
        repeat (budget) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", budget);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst_b      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        cur_test   = "reset";
        errors     = 0;
        mon_errors = 0;
        tests_run  = 0;
        tests_failed = 0;
        acts       = 0;
        ref_runs   = 0;
        ref_cycles = 0;
        ref_len    = 0;
        next_col   = 0;
        row_open   = 1'b0;
        exp_base   = 0;
        acts_base  = 0;
        void'($urandom(32'hfc737f95));

        // refresh and completion need transfers long enough to overlap them
        for (i = 0; i < NXFER; i++) begin
            xfer_len[i] = (i == 7 || i == 8) ? 6 + int'($urandom % 18) : 1 + int'($urandom % 24);
        end
        for (i = 0; i < NXFER; i++) begin
            budget += 20 * xfer_len[i] + 200;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_b = 1'b0;

        open_test("register_readback");
        wdata = $urandom;
        write_reg(`DRAM_REG_ADDR, wdata);
        read_reg(`DRAM_REG_ADDR, rdata);
        if (rdata != (wdata & 32'h0000_077f)) report_mismatch("ADDR", wdata & 32'h77f, rdata);
        wdata = $urandom;
        write_reg(`DRAM_REG_LEN, wdata);
        read_reg(`DRAM_REG_LEN, rdata);
        if (rdata != (wdata & 32'h0000_03ff)) report_mismatch("LEN", wdata & 32'h3ff, rdata);
        wdata = $urandom;
        write_reg(`DRAM_REG_REFI, wdata);
        read_reg(`DRAM_REG_REFI, rdata);
        if (rdata != (wdata & 32'h0000_ffff)) report_mismatch("REFI", wdata & 32'hffff, rdata);
        write_reg(`DRAM_REG_REFI, 32'h0);
        repeat (2 * `DRAM_REF_CYCLES) @(negedge clk);   // let a running burst end
        close_test();

        open_test("row_walk");
        for (i = 0; i < 6; i++) begin
            bank = (i == 0) ? `DRAM_BANKS - 1 : int'($urandom % `DRAM_BANKS);
            row  = (i == 0) ? `DRAM_ROWS - 1 - int'($urandom % 4) : int'($urandom % `DRAM_ROWS);
            run_transfer(bank, row, xfer_len[i], 0);
            wait_done(stat);
            if (acts - acts_base != xfer_len[i]) begin
                report_mismatch("ACT count", xfer_len[i], acts - acts_base);
            end
        end
        close_test();

        open_test("column_burst");
        run_transfer(int'($urandom % `DRAM_BANKS), int'($urandom % `DRAM_ROWS), xfer_len[6], 0);
        wait_done(stat);
        if (acts - acts_base != xfer_len[6]) begin
            report_mismatch("ACT count", xfer_len[6], acts - acts_base);
        end
        close_test();

        open_test("refresh_placement");
        runs_before = ref_runs;
        refi = 6 + int'($urandom % 20);
        run_transfer(int'($urandom % `DRAM_BANKS), int'($urandom % `DRAM_ROWS), xfer_len[7], refi);
        wait_done(stat);
        write_reg(`DRAM_REG_REFI, 32'h0);
        repeat (2 * `DRAM_REF_CYCLES) @(negedge clk);
        read_reg(`DRAM_REG_STAT, stat);
        if (stat[31:16] != ref_runs[15:0]) begin
            report_mismatch("refcnt", ref_runs, {16'h0, stat[31:16]});
        end
        if (ref_runs == runs_before) report_error("no refresh burst seen with a small interval");
        if (acts - acts_base != xfer_len[7]) begin
            report_mismatch("ACT count", xfer_len[7], acts - acts_base);
        end
        close_test();

        open_test("completion");
        run_transfer(int'($urandom % `DRAM_BANKS), int'($urandom % `DRAM_ROWS), xfer_len[8], 0);
        read_reg(`DRAM_REG_STAT, stat);
        if (stat[0] != 1'b1) report_mismatch("busy during transfer", 1, {31'h0, stat[0]});
        write_reg(`DRAM_REG_CTRL, 32'h1);   // must be ignored
        wait_done(stat);
        if (stat[0] != 1'b0) report_mismatch("busy after done", 0, {31'h0, stat[0]});
        if (acts - acts_base != xfer_len[8]) begin
            report_mismatch("ACT count", xfer_len[8], acts - acts_base);
        end
        close_test();

        open_test("refresh_off");
        cycles_before = ref_cycles;
        run_transfer(int'($urandom % `DRAM_BANKS), int'($urandom % `DRAM_ROWS), xfer_len[9], 0);
        wait_done(stat);
        if (ref_cycles != cycles_before) report_mismatch("REF cycles", 0, ref_cycles - cycles_before);
        close_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: logic/dram_ctrl_top.sv
// read data is not modelled, bus carries command and address only
`timescale 1ns/1ps

module dram_ctrl_top import dram_pkg::*; (
    input  logic        clk,
    input  logic        rst_b,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output dram_bus_s   bus
);

    dram_cfg_s cfg;
    dram_cmd_e cmd;
    bank_t     bank;
    row_t      row;
    col_t      col;
    logic      start;
    logic      busy;
    logic      done_set;
    logic      ref_served;
    logic      ref_req;
    logic      ref_ack;
    logic      act;
    logic      rd;
    logic      row_step;

    dram_apb_regs u_regs (
        .clk        (clk),
        .rst_b      (rst_b),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .busy       (busy),
        .done_set   (done_set),
        .ref_served (ref_served),
        .cfg        (cfg),
        .start      (start)
    );

    dram_refresh_timer u_refresh (
        .clk     (clk),
        .rst_b   (rst_b),
        .refi    (cfg.refi),
        .ref_ack (ref_ack),
        .ref_req (ref_req)
    );

    dram_addr_gen u_addr (
        .clk      (clk),
        .rst_b    (rst_b),
        .start    (start),
        .cfg      (cfg),
        .act      (act),
        .rd       (rd),
        .row_step (row_step),
        .bank     (bank),
        .row      (row),
        .col      (col)
    );

    dram_ctrl_fsm u_fsm (
        .clk        (clk),
        .rst_b      (rst_b),
        .start      (start),
        .len        (cfg.len),
        .ref_req    (ref_req),
        .cmd        (cmd),
        .act        (act),
        .rd         (rd),
        .row_step   (row_step),
        .ref_ack    (ref_ack),
        .ref_served (ref_served),
        .busy       (busy),
        .done_set   (done_set)
    );

    assign bus = '{cmd: cmd, bank: bank, row: row, col: col};

endmodule

// File: logic/dram_ctrl_fsm.sv
// one open row at a time, refresh only with all banks closed, len of zero finishes at once
`timescale 1ns/1ps
`include "dram_defines.svh"

module dram_ctrl_fsm import dram_pkg::*; (
    input  logic      clk,
    input  logic      rst_b,
    input  logic      start,
    input  len_t      len,
    input  logic      ref_req,
    output dram_cmd_e cmd,
    output logic      act,
    output logic      rd,
    output logic      row_step,
    output logic      ref_ack,
    output logic      ref_served,
    output logic      busy,
    output logic      done_set
);

    localparam int REF_W = $clog2(`DRAM_REF_CYCLES);

    fsm_state_e       state;
    fsm_state_e       state_nxt;
    col_t             col_cnt;
    len_t             rows_left;
    logic             xfer;
    logic [REF_W-1:0] ref_cnt;

    logic start_ok;
    logic last_row;
    logic last_col;
    logic ref_last;

    assign start_ok = start && (len != '0);
    assign last_row = (rows_left == len_t'(1));
    assign last_col = (col_cnt == col_t'(`DRAM_COLS - 1));
    assign ref_last = (ref_cnt == REF_W'(`DRAM_REF_CYCLES - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (ref_req) begin
                    state_nxt = REFRESH;   // pending refresh goes first
                end else if (start_ok) begin
                    state_nxt = ACTIVATE;
                end
            end
            ACTIVATE: state_nxt = READ;
            READ: begin
                if (last_col) begin
                    state_nxt = PRECHARGE;
                end
            end
            PRECHARGE: begin
                if (ref_req) begin
                    state_nxt = REFRESH;
                end else if (!last_row) begin
                    state_nxt = ACTIVATE;
                end else begin
                    state_nxt = IDLE;
                end
            end
            REFRESH: begin
                if (ref_last) begin
                    state_nxt = (xfer || start_ok) ? ACTIVATE : IDLE;   // resume rows
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_comb begin
        case (state)
            ACTIVATE:  cmd = CMD_ACT;
            READ:      cmd = CMD_RD;
            PRECHARGE: cmd = CMD_PRE;
            REFRESH:   cmd = CMD_REF;
            default:   cmd = CMD_NOP;
        endcase
    end

    assign act        = (state == ACTIVATE);
    assign rd         = (state == READ);
    assign row_step   = (state == PRECHARGE);
    assign ref_ack    = (state == REFRESH) && (ref_cnt == '0);
    assign ref_served = (state == REFRESH) && ref_last;
    assign done_set   = (row_step && last_row) || (start && (len == '0));
    assign busy       = xfer;

    always_ff @(posedge clk or posedge rst_b) begin
        if (rst_b) begin
            state     <= IDLE;
            col_cnt   <= '0;
            rows_left <= '0;
            xfer      <= 1'b0;
            ref_cnt   <= '0;
        end else begin
            state <= state_nxt;

            if (act) begin
                col_cnt <= '0;
            end else if (rd) begin
                col_cnt <= col_cnt + 1'b1;
            end

            if (start_ok) begin
                rows_left <= len;
                xfer      <= 1'b1;
            end else begin
                if (row_step) begin
                    rows_left <= rows_left - 1'b1;
                end
                if (done_set) begin
                    xfer <= 1'b0;
                end
            end

            if (state == REFRESH) begin
                ref_cnt <= ref_last ? '0 : ref_cnt + 1'b1;
            end
        end
    end

    // a read must sit inside an ACT..PRE window
    a_rd_open: assert property (@(posedge clk) disable iff (rst_b)
        cmd == CMD_RD |-> $past(cmd) inside {CMD_ACT, CMD_RD})
        else $error("RD issued without an open row");

    // refresh only after PRE, from idle, or continuing a burst
    a_ref_closed: assert property (@(posedge clk) disable iff (rst_b)
        cmd == CMD_REF |-> $past(cmd) inside {CMD_NOP, CMD_PRE, CMD_REF})
        else $error("REF issued while a row is open");

    // new row only after PRE, refresh or idle, never on top of a read burst
    a_act_rd: assert property (@(posedge clk) disable iff (rst_b)
        act |-> $past(cmd) inside {CMD_NOP, CMD_PRE, CMD_REF})
        else $error("act asserted while a row is open");

endmodule

// File: logic/dram_addr_gen.sv
// start wins over any step in the same cycle, rows carry into banks and banks wrap to zero
`timescale 1ns/1ps
`include "dram_defines.svh"

module dram_addr_gen import dram_pkg::*; (
    input  logic      clk,
    input  logic      rst_b,
    input  logic      start,
    input  dram_cfg_s cfg,
    input  logic      act,
    input  logic      rd,
    input  logic      row_step,
    output bank_t     bank,
    output row_t      row,
    output col_t      col
);

    logic row_wrap;
    logic bank_wrap;

    assign row_wrap  = (row == row_t'(`DRAM_ROWS - 1));
    assign bank_wrap = (bank == bank_t'(`DRAM_BANKS - 1));

    always_ff @(posedge clk or posedge rst_b) begin
        if (rst_b) begin
            bank <= '0;
            row  <= '0;
            col  <= '0;
        end else if (start) begin
            bank <= cfg.bank;
            row  <= cfg.row;
            col  <= '0;
        end else begin
            if (act) begin
                col <= '0;
            end else if (rd) begin
                col <= (col == col_t'(`DRAM_COLS - 1)) ? '0 : col + 1'b1;
            end

            if (row_step) begin
                if (row_wrap) begin
                    row  <= '0;
                    bank <= bank_wrap ? '0 : bank + 1'b1;   // carry
                end else begin
                    row <= row + 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/dram_refresh_timer.sv
// request rises about refi cycles after the last ack, a new refi value takes effect on the next reload
`timescale 1ns/1ps

module dram_refresh_timer import dram_pkg::*; (
    input  logic  clk,
    input  logic  rst_b,
    input  refi_t refi,
    input  logic  ref_ack,
    output logic  ref_req
);

    refi_t cnt;

    always_ff @(posedge clk or posedge rst_b) begin
        if (rst_b) begin
            cnt     <= '0;
            ref_req <= 1'b0;
        end else if (refi == '0) begin
            cnt     <= '0;   // refresh off
            ref_req <= 1'b0;
        end else if (ref_ack) begin
            cnt     <= refi;
            ref_req <= 1'b0;
        end else if (!ref_req) begin
            if (cnt == refi_t'(1)) begin
                cnt     <= '0;
                ref_req <= 1'b1;
            end else if (cnt == '0) begin
                cnt <= refi;   // first load after enabling
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

// File: logic/dram_apb_regs.sv
// APB slave with zero wait states, ADDR holds row in bits 6:0 and bank in 10:8, start ignored when busy
`timescale 1ns/1ps
`include "dram_defines.svh"

module dram_apb_regs import dram_pkg::*; (
    input  logic        clk,
    input  logic        rst_b,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    input  logic        busy,
    input  logic        done_set,
    input  logic        ref_served,
    output dram_cfg_s   cfg,
    output logic        start
);

    localparam int BANK_LSB = 8;

    logic    wr_en;
    logic    done;
    refcnt_t refcnt;

    assign wr_en  = psel && penable && pwrite;   // access phase only
    assign pready = 1'b1;

    always_ff @(posedge clk or posedge rst_b) begin
        if (rst_b) begin
            cfg    <= '0;
            start  <= 1'b0;
            done   <= 1'b0;
            refcnt <= '0;
        end else begin
            start <= wr_en && (paddr == `DRAM_REG_CTRL) && pwdata[0] && !busy && !start;

            if (wr_en) begin
                case (paddr)
                    `DRAM_REG_ADDR: begin
                        cfg.row  <= pwdata[0 +: $bits(row_t)];
                        cfg.bank <= pwdata[BANK_LSB +: $bits(bank_t)];
                    end
                    `DRAM_REG_LEN:  cfg.len  <= pwdata[0 +: $bits(len_t)];
                    `DRAM_REG_REFI: cfg.refi <= pwdata[0 +: $bits(refi_t)];
                    default: ;
                endcase
            end

            // a zero-length start sets done in the same cycle as the pulse
            if (done_set) begin
                done <= 1'b1;
            end else if (start) begin
                done <= 1'b0;
            end

            if (ref_served) begin
                refcnt <= refcnt + 1'b1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            `DRAM_REG_ADDR: begin
                prdata[0 +: $bits(row_t)]         = cfg.row;
                prdata[BANK_LSB +: $bits(bank_t)] = cfg.bank;
            end
            `DRAM_REG_LEN:  prdata[0 +: $bits(len_t)]  = cfg.len;
            `DRAM_REG_REFI: prdata[0 +: $bits(refi_t)] = cfg.refi;
            `DRAM_REG_STAT: begin
                prdata[0]     = busy;
                prdata[1]     = done;
                prdata[31:16] = refcnt;
            end
            default: ;   // CTRL reads as zero
        endcase
    end

endmodule

// File: logic/dram_pkg.sv
// field widths follow the geometry macros, struct layouts are fixed and shared by every block
`include "dram_defines.svh"

package dram_pkg;

    typedef logic [$clog2(`DRAM_BANKS)-1:0] bank_t;
    typedef logic [$clog2(`DRAM_ROWS)-1:0]  row_t;
    typedef logic [$clog2(`DRAM_COLS)-1:0]  col_t;

    typedef logic [9:0]  len_t;    // rows per transfer
    typedef logic [15:0] refi_t;   // zero disables refresh
    typedef logic [15:0] refcnt_t;

    typedef enum logic [2:0] {
        CMD_NOP = 3'd0,
        CMD_ACT = 3'd1,
        CMD_RD  = 3'd2,
        CMD_PRE = 3'd3,
        CMD_REF = 3'd4
    } dram_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        ACTIVATE,
        READ,
        PRECHARGE,
        REFRESH
    } fsm_state_e;

    typedef struct packed {
        bank_t bank;
        row_t  row;
        len_t  len;
        refi_t refi;
    } dram_cfg_s;

    // command bus as seen on the top-level port
    typedef struct packed {
        dram_cmd_e cmd;
        bank_t     bank;
        row_t      row;
        col_t      col;
    } dram_bus_s;

endpackage

// File: include/dram_defines.svh
// geometry must stay a power of two per field, APB offsets assume a byte-addressed 8-bit paddr
`ifndef DRAM_DEFINES_SVH
`define DRAM_DEFINES_SVH

// array geometry
`define DRAM_BANKS      8
`define DRAM_ROWS       128
`define DRAM_COLS       8

// consecutive REF cycles per refresh burst
`define DRAM_REF_CYCLES 4

// APB register byte offsets
`define DRAM_REG_CTRL   8'h00
`define DRAM_REG_ADDR   8'h04
`define DRAM_REG_LEN    8'h08
`define DRAM_REG_REFI   8'h0C
`define DRAM_REG_STAT   8'h10

`endif
